// File: riscv_core.f
+incdir+include
hw/rv_pkg.sv
hw/pc_unit.sv
hw/control_unit.sv
hw/imm_gen.sv
hw/alu.sv
hw/reg_file.sv
hw/core_memories.sv
hw/riscv_core.sv
verification/tb_clock.sv
verification/riscv_core_properties.sv
verification/riscv_core_tb.sv

// File: Makefile
# Verilator flow for the riscv_core testbench

TOP := riscv_core_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f riscv_core.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f riscv_core.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/riscv_core_tb.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module riscv_core_tb;

  localparam int NT = 11;
  localparam int PROG_WORDS = 10;
  localparam int MAX_ST = 8;
  localparam int RUN_CYCLES = 40;
  localparam int HOLD = 10;
  // tests x (reset + load + run + hold) cycles of 100 ns, plus power-on
  localparam longint WATCHDOG_NS = NT * (3 + PROG_WORDS + RUN_CYCLES + HOLD) * 100 + 1000;
  localparam logic [31:0] ECALL = 32'h0000_0073;

  logic clk, por, tb_reset, reset, prog_we, halted, store_en;
  rv_pkg::word_t prog_addr, prog_data, pc, store_addr, store_data;

  // test table
  string       names [NT];
  logic [31:0] prog [NT][PROG_WORDS];
  logic [31:0] exp_addr [NT][MAX_ST];
  logic [31:0] exp_data [NT][MAX_ST];
  int          exp_n [NT];
  int          n_tests;
  int          n_instr;
  logic [31:0] got_addr [MAX_ST];
  logic [31:0] got_data [MAX_ST];
  logic [31:0] lfsr_state = 32'h5049;
  int          errors = 0;

  assign reset = por | tb_reset;

  tb_clock clk0 (.clk(clk), .por(por));

  riscv_core dut0 (
    .clk(clk), .reset(reset), .prog_we(prog_we), .prog_addr(prog_addr),
    .prog_data(prog_data), .pc(pc), .halted(halted), .store_en(store_en),
    .store_addr(store_addr), .store_data(store_data)
  );

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  // n bits land in the low end, the rest stays zero
  function automatic logic [11:0] lfsr_bits(int n);
    logic [11:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v[i] = fb;
    end
    return v;
  endfunction

  function automatic logic [31:0] sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // instruction encoders
  function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `RV_OP_ARITH};
  endfunction

  function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] sw(logic [4:0] rs2, logic [11:0] off, logic [4:0] rs1);
    return {off[11:5], rs2, rs1, 3'b010, off[4:0], `RV_OP_STORE};
  endfunction

  function automatic logic [31:0] b_type(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
  endfunction

  function automatic logic [31:0] jal(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
  endfunction

  function automatic logic [31:0] addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return i_type(imm, rs1, `RV_F3_ADD, rd, `RV_OP_ARITH_IMM);
  endfunction

  // the core halts on the first ecall word of the program
  function automatic logic [31:0] first_ecall_addr(int t);
    for (int i = 0; i < PROG_WORDS; i++) begin
      if (prog[t][i] == ECALL) begin
        return i * 4;
      end
    end
    return PROG_WORDS * 4;
  endfunction

  // table building, unused slots hold ecall
  task automatic new_test(string name);
    n_tests++;
    names[n_tests-1] = name;
    exp_n[n_tests-1] = 0;
    n_instr = 0;
    for (int i = 0; i < PROG_WORDS; i++) begin
      prog[n_tests-1][i] = ECALL;
    end
  endtask

  task automatic emit(logic [31:0] w);
    prog[n_tests-1][n_instr] = w;
    n_instr++;
  endtask

  task automatic expect_store(logic [31:0] a, logic [31:0] d);
    exp_addr[n_tests-1][exp_n[n_tests-1]] = a;
    exp_data[n_tests-1][exp_n[n_tests-1]] = d;
    exp_n[n_tests-1]++;
  endtask

  task automatic build_tests();
    logic [11:0] r1, r2, r3, r4, r5;
    logic [11:0] s1, s2;
    logic [31:0] a, b;
    n_tests = 0;
    r1 = lfsr_bits(12);
    r2 = lfsr_bits(12);
    r3 = lfsr_bits(12);
    r4 = lfsr_bits(12);
    r5 = lfsr_bits(12);
    s1 = lfsr_bits(5);
    s2 = lfsr_bits(5);
    // reference model, expected values from the isa rules
    a = sext12(r1);
    b = sext12(r2);
    new_test("r_arith_a");
    emit(addi(1, 0, r1));
    emit(addi(2, 0, r2));
    emit(r_type(7'd0, 2, 1, `RV_F3_ADD, 3));
    emit(sw(3, 0, 0));
    emit(r_type(`RV_F7_SUB, 2, 1, `RV_F3_ADD, 4));
    emit(sw(4, 4, 0));
    emit(r_type(7'd0, 2, 1, `RV_F3_SLL, 5));
    emit(sw(5, 8, 0));
    expect_store(0, a + b);
    expect_store(4, a - b);
    expect_store(8, a << b[4:0]);
    new_test("r_arith_b");
    emit(addi(1, 0, r1));
    emit(addi(2, 0, r2));
    emit(r_type(7'd0, 2, 1, `RV_F3_XOR, 3));
    emit(sw(3, 0, 0));
    emit(r_type(7'd0, 2, 1, `RV_F3_OR, 4));
    emit(sw(4, 4, 0));
    emit(r_type(7'd0, 2, 1, `RV_F3_AND, 5));
    emit(sw(5, 8, 0));
    expect_store(0, a ^ b);
    expect_store(4, a | b);
    expect_store(8, a & b);
    new_test("imm_ops");
    emit(addi(1, 0, r1));
    emit(i_type(r3, 1, `RV_F3_XOR, 3, `RV_OP_ARITH_IMM));
    emit(sw(3, 0, 0));
    emit(i_type(r4, 1, `RV_F3_OR, 4, `RV_OP_ARITH_IMM));
    emit(sw(4, 4, 0));
    emit(i_type(r5, 1, `RV_F3_AND, 5, `RV_OP_ARITH_IMM));
    emit(sw(5, 8, 0));
    expect_store(0, a ^ sext12(r3));
    expect_store(4, a | sext12(r4));
    expect_store(8, a & sext12(r5));
    new_test("shifts");
    emit(addi(1, 0, r1));
    emit(addi(2, 0, r2));
    emit(r_type(7'd0, 2, 1, `RV_F3_SRL, 3));
    emit(sw(3, 0, 0));
    emit(i_type(s1, 1, `RV_F3_SLL, 4, `RV_OP_ARITH_IMM));
    emit(sw(4, 4, 0));
    emit(i_type(s2, 1, `RV_F3_SRL, 5, `RV_OP_ARITH_IMM));
    emit(sw(5, 8, 0));
    expect_store(0, a >> b[4:0]);
    expect_store(4, a << s1);
    expect_store(8, a >> s2);
    new_test("load_store");
    emit(addi(1, 0, 12'd123));
    emit(sw(1, 16, 0));
    emit(i_type(12'd16, 0, 3'b010, 2, `RV_OP_LOAD));
    emit(addi(3, 2, 12'd5));
    emit(sw(3, 20, 0));
    emit(i_type(12'd20, 0, 3'b010, 4, `RV_OP_LOAD));
    emit(r_type(7'd0, 2, 4, `RV_F3_ADD, 5));
    emit(sw(5, 24, 0));
    expect_store(16, 123);
    expect_store(20, 128);
    expect_store(24, 251);
    // equal operands, beq taken and bne falls through
    new_test("beq_bne_equal");
    emit(addi(1, 0, 12'd5));
    emit(addi(2, 0, 12'd5));
    emit(b_type(`RV_F3_BEQ, 1, 2, 13'd8));
    emit(sw(1, 0, 0));
    emit(b_type(`RV_F3_BNE, 1, 2, 13'd8));
    emit(sw(2, 4, 0));
    expect_store(4, 5);
    // different operands, beq falls through and bne taken
    new_test("beq_bne_differ");
    emit(addi(1, 0, 12'd5));
    emit(addi(2, 0, 12'hffd));
    emit(b_type(`RV_F3_BEQ, 1, 2, 13'd8));
    emit(sw(1, 0, 0));
    emit(b_type(`RV_F3_BNE, 1, 2, 13'd8));
    emit(sw(2, 4, 0));
    emit(sw(1, 8, 0));
    expect_store(0, 5);
    expect_store(8, 5);
    // 0x7fffffff vs -2, the difference wraps negative
    new_test("blt_bge_overflow");
    emit(addi(1, 0, 12'hfff));
    emit(i_type(12'd1, 1, `RV_F3_SRL, 1, `RV_OP_ARITH_IMM));
    emit(addi(2, 0, 12'hffe));
    emit(b_type(`RV_F3_BLT, 1, 2, 13'd8));
    emit(sw(1, 0, 0));
    emit(b_type(`RV_F3_BGE, 1, 2, 13'd8));
    emit(sw(2, 4, 0));
    emit(b_type(`RV_F3_BLT, 2, 1, 13'd8));
    emit(sw(2, 8, 0));
    expect_store(0, 32'h7fff_ffff);
    new_test("blt_bge_small");
    emit(addi(1, 0, 12'hffc));
    emit(addi(2, 0, 12'd3));
    emit(b_type(`RV_F3_BLT, 1, 2, 13'd8));
    emit(sw(1, 0, 0));
    emit(b_type(`RV_F3_BGE, 1, 2, 13'd8));
    emit(sw(2, 4, 0));
    expect_store(4, 3);
    // jal at 0 links 4, jalr at 16 links 20, target 25 lands on 24
    new_test("jumps");
    emit(jal(1, 21'd8));
    emit(sw(0, 0, 0));
    emit(sw(1, 0, 0));
    emit(addi(2, 0, 12'd25));
    emit(i_type(12'd0, 2, 3'b000, 3, `RV_OP_JALR));
    emit(sw(0, 4, 0));
    emit(sw(3, 4, 0));
    expect_store(0, 4);
    expect_store(4, 20);
    // sw sits at pc 0 during the load under reset
    // the store after ecall must never retire
    new_test("x0_and_halt");
    emit(sw(0, 12, 0));
    emit(addi(0, 0, 12'd77));
    emit(sw(0, 0, 0));
    emit(addi(1, 0, 12'd9));
    emit(r_type(7'd0, 1, 1, `RV_F3_ADD, 0));
    emit(sw(0, 4, 0));
    emit(ECALL);
    emit(sw(1, 8, 0));
    expect_store(12, 0);
    expect_store(0, 0);
    expect_store(4, 0);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    int          n_got;
    int          errs_before;
    bit          done;
    logic [31:0] hold_pc;
    tb_reset  = 1'b1;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    build_tests();
    for (int t = 0; t < n_tests; t++) begin
      errs_before = errors;
      @(negedge clk);
      tb_reset = 1'b1;
      // load under reset, one word per falling edge
      for (int i = 0; i < PROG_WORDS; i++) begin
        prog_we   = 1'b1;
        prog_addr = i;
        prog_data = prog[t][i];
        @(negedge clk);
      end
      prog_we  = 1'b0;
      tb_reset = 1'b0;
      n_got = 0;
      done  = 1'b0;
      // sample mid low phase, outputs settled since the rising edge
      for (int c = 0; c < RUN_CYCLES && !done; c++) begin
        #10;
        if (halted) begin
          done = 1'b1;
        end else begin
          if (store_en) begin
            if (n_got < MAX_ST) begin
              got_addr[n_got] = store_addr;
              got_data[n_got] = store_data;
            end
            n_got++;
          end
          @(negedge clk);
        end
      end
      assert (done) else begin
        $display("test %s: core did not halt within %0d cycles", names[t], RUN_CYCLES);
        errors++;
      end
      if (done) begin
        hold_pc = first_ecall_addr(t);
        assert (pc == hold_pc) else begin
          $display("ERR %0t: %s halted at pc %h expected %h", $time, names[t], pc, hold_pc);
          errors++;
        end
        repeat (HOLD) begin
          @(negedge clk);
          #10;
          assert (halted && pc == hold_pc && !store_en) else begin
            $display("ERR %0t: %s left halt (halted %b pc %h store_en %b)",
                     $time, names[t], halted, pc, store_en);
            errors++;
          end
        end
      end
      assert (n_got == exp_n[t]) else begin
        $display("test %s: wrong number of stores, got %0d expected %0d",
                 names[t], n_got, exp_n[t]);
        errors++;
      end
      for (int k = 0; k < exp_n[t] && k < n_got && k < MAX_ST; k++) begin
        assert (got_addr[k] == exp_addr[t][k] && got_data[k] == exp_data[t][k]) else begin
          $display("ERR %0t: %s store %0d got [%h]=%h expected [%h]=%h", $time, names[t],
                   k, got_addr[k], got_data[k], exp_addr[t][k], exp_data[t][k]);
          errors++;
        end
      end
      $display("test %s: %s", names[t], (errors == errs_before) ? "ok" : "mismatch");
    end
    // bound property failures count too
    errors += dut0.props0.n_fail;
    $display("tests run %0d, errors %0d", n_tests, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: verification/riscv_core_properties.sv
`timescale 1ns/1ps

module riscv_core_properties (
  input logic        clk,
  input logic        reset,
  input logic        halted,
  input logic        store_en,
  input logic [31:0] pc
);

  // number of failed properties so far
  int n_fail = 0;

  // no store may leave the core while it is held or halted
  no_store_when_blocked: assert property (
    @(posedge clk) (reset || halted) |-> !store_en
  ) else begin
    n_fail++;
    $error("store_en high during reset or halt");
  end

  // fetch address stays on a word boundary
  pc_word_aligned: assert property (
    @(posedge clk) disable iff (reset) pc[1:0] == 2'b00
  ) else begin
    n_fail++;
    $error("pc not word aligned: %h", pc);
  end

  // halt freezes the pc until the next reset
  pc_frozen_in_halt: assert property (
    @(posedge clk) disable iff (reset) halted |=> $stable(pc)
  ) else begin
    n_fail++;
    $error("pc moved while halted");
  end

endmodule

bind riscv_core riscv_core_properties props0 (
  .clk(clk),
  .reset(reset),
  .halted(halted),
  .store_en(store_en),
  .pc(pc)
);

// File: verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic por
);

  // 100 ns period
  initial begin
    clk = 1'b0;
    por = 1'b1;
    // power-on reset for 3 cycles, released on a falling edge
    repeat (3) @(posedge clk);
    @(negedge clk);
    por = 1'b0;
  end

  always #50 clk = ~clk;

endmodule

// File: hw/riscv_core.sv
`timescale 1ns/1ps

module riscv_core (
  input  logic          clk,
  input  logic          reset,
  input  logic          prog_we,
  input  rv_pkg::word_t prog_addr,
  input  rv_pkg::word_t prog_data,
  output rv_pkg::word_t pc,
  output logic          halted,
  output logic          store_en,
  output rv_pkg::word_t store_addr,
  output rv_pkg::word_t store_data
);

  rv_pkg::word_t    instr;
  rv_pkg::word_t    imm;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  rv_pkg::word_t    alu_result;
  rv_pkg::word_t    load_data;
  rv_pkg::alu_op_t  alu_op;
  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  rv_pkg::reg_idx_t rd;
  rv_pkg::funct3_t  funct3;
  logic             is_jal;
  logic             is_jalr;
  logic             branch;
  logic             bcond;
  logic             mem_read;
  logic             mem_to_reg;
  logic             mem_write;
  logic             alu_src;
  logic             reg_write;
  logic             pc_to_reg;
  logic             is_ecall;
  logic             write_block;

  // register and function fields
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];

  // no writes while the program is loaded or after ecall
  assign write_block = halted | reset;

  pc_unit u_pc (
    .clk(clk), .reset(reset), .is_jal(is_jal), .is_jalr(is_jalr),
    .branch(branch), .bcond(bcond), .is_ecall(is_ecall), .imm(imm),
    .alu_result(alu_result), .pc(pc), .halted(halted)
  );

  inst_mem u_imem (
    .clk(clk), .prog_we(prog_we), .prog_addr(prog_addr),
    .prog_data(prog_data), .pc(pc), .instr(instr)
  );

  control_unit u_ctrl (
    .instr(instr), .halted(write_block), .is_jal(is_jal), .is_jalr(is_jalr),
    .branch(branch), .mem_read(mem_read), .mem_to_reg(mem_to_reg),
    .mem_write(mem_write), .alu_src(alu_src), .reg_write(reg_write),
    .pc_to_reg(pc_to_reg), .is_ecall(is_ecall), .alu_op(alu_op)
  );

  imm_gen u_imm (.instr(instr), .imm(imm));

  reg_file u_rf (
    .clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .rd(rd),
    .reg_write(reg_write), .mem_to_reg(mem_to_reg), .pc_to_reg(pc_to_reg),
    .alu_result(alu_result), .load_data(load_data), .pc(pc),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  alu u_alu (
    .alu_op(alu_op), .funct3(funct3), .src_a(rs1_data), .rs2_data(rs2_data),
    .imm(imm), .alu_src(alu_src), .result(alu_result), .bcond(bcond)
  );

  data_mem u_dmem (
    .clk(clk), .mem_write(mem_write), .mem_read(mem_read),
    .addr(alu_result), .wdata(rs2_data), .rdata(load_data)
  );

  // every executed sw shows up here for checking
  assign store_en   = mem_write;
  assign store_addr = alu_result;
  assign store_data = rs2_data;

endmodule

// File: hw/core_memories.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module inst_mem (
  input  logic          clk,
  input  logic          prog_we,
  input  rv_pkg::word_t prog_addr,
  input  rv_pkg::word_t prog_data,
  input  rv_pkg::word_t pc,
  output rv_pkg::word_t instr
);

  localparam int IMEM_AW = $clog2(`RV_IMEM_WORDS);

  rv_pkg::word_t mem [`RV_IMEM_WORDS];

  // program load, prog_addr is a word index
  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_addr[IMEM_AW-1:0]] <= prog_data;
    end
  end

  // fetch, pc is a byte address and always word aligned
  assign instr = mem[pc[IMEM_AW+1:2]];

endmodule

module data_mem (
  input  logic          clk,
  input  logic          mem_write,
  input  logic          mem_read,
  input  rv_pkg::word_t addr,
  input  rv_pkg::word_t wdata,
  output rv_pkg::word_t rdata
);

  localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

  rv_pkg::word_t             mem [`RV_DMEM_WORDS];
  logic [DMEM_AW-1:0] widx;

  // word accesses only, low address bits dropped
  assign widx = addr[DMEM_AW+1:2];

  always_ff @(posedge clk) begin
    if (mem_write) begin
      mem[widx] <= wdata;
    end
  end

  // reads zero unless a load is in flight
  assign rdata = mem_read ? mem[widx] : '0;

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  rv_pkg::reg_idx_t rd,
  input  logic             reg_write,
  input  logic             mem_to_reg,
  input  logic             pc_to_reg,
  input  rv_pkg::word_t    alu_result,
  input  rv_pkg::word_t    load_data,
  input  rv_pkg::word_t    pc,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);

  rv_pkg::word_t regs [32];
  rv_pkg::word_t wb_data;

  // write-back select, the link value wins over load data
  always_comb begin
    if (pc_to_reg) begin
      wb_data = pc + 32'd4;
    end else if (mem_to_reg) begin
      wb_data = load_data;
    end else begin
      wb_data = alu_result;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_write && rd != 5'd0) begin
      regs[rd] <= wb_data;
    end
  end

  // asynchronous reads, x0 hardwired
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module alu (
  input  rv_pkg::alu_op_t alu_op,
  input  rv_pkg::funct3_t funct3,
  input  rv_pkg::word_t   src_a,
  input  rv_pkg::word_t   rs2_data,
  input  rv_pkg::word_t   imm,
  input  logic            alu_src,
  output rv_pkg::word_t   result,
  output logic            bcond
);

  rv_pkg::word_t src_b;
  logic [4:0]    shamt;

  // operand mux
  assign src_b = alu_src ? imm : rs2_data;
  assign shamt = src_b[4:0];

  always_comb begin
    bcond = 1'b0;
    case (alu_op)
      `RV_ALU_ADD: result = src_a + src_b;
      `RV_ALU_SUB: begin
        result = src_a - src_b;
        // branch test on the operands themselves, not on the difference sign,
        // so an overflowing subtraction still compares correctly
        case (funct3)
          `RV_F3_BEQ: bcond = (src_a == src_b);
          `RV_F3_BNE: bcond = (src_a != src_b);
          `RV_F3_BLT: bcond = ($signed(src_a) < $signed(src_b));
          `RV_F3_BGE: bcond = ($signed(src_a) >= $signed(src_b));
          default:    bcond = 1'b0;
        endcase
      end
      `RV_ALU_SLL: result = src_a << shamt;
      `RV_ALU_XOR: result = src_a ^ src_b;
      `RV_ALU_OR:  result = src_a | src_b;
      `RV_ALU_AND: result = src_a & src_b;
      // logical shift, sra is not supported
      `RV_ALU_SRL: result = src_a >> shamt;
      default:     result = '0;
    endcase
  end

endmodule

// File: hw/imm_gen.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module imm_gen (
  input  rv_pkg::word_t instr,
  output rv_pkg::word_t imm
);

  rv_pkg::opcode_t opcode;

  assign opcode = instr[6:0];

  always_comb begin
    case (opcode)
      // I format, shift amounts also land here and the alu takes imm[4:0]
      `RV_OP_ARITH_IMM, `RV_OP_LOAD, `RV_OP_JALR: begin
        imm = {{21{instr[31]}}, instr[30:20]};
      end
      // S format, split field
      `RV_OP_STORE: begin
        imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
      end
      // B format, offset in half words
      `RV_OP_BRANCH: begin
        imm = {{20{instr[31]}}, instr[7], instr[30:25],
               instr[11:8], 1'b0};
      end
      // J format
      `RV_OP_JAL: begin
        imm = {{12{instr[31]}}, instr[19:12], instr[20],
               instr[30:21], 1'b0};
      end
      // no immediate, e.g. register arithmetic or ecall
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

// File: hw/control_unit.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module control_unit (
  input  rv_pkg::word_t   instr,
  input  logic            halted,
  output logic            is_jal,
  output logic            is_jalr,
  output logic            branch,
  output logic            mem_read,
  output logic            mem_to_reg,
  output logic            mem_write,
  output logic            alu_src,
  output logic            reg_write,
  output logic            pc_to_reg,
  output logic            is_ecall,
  output rv_pkg::alu_op_t alu_op
);

  rv_pkg::opcode_t opcode;
  rv_pkg::funct3_t funct3;
  logic [6:0]      funct7;
  logic            writes_rd;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // main decoder
  assign is_jal     = (opcode == `RV_OP_JAL);
  assign is_jalr    = (opcode == `RV_OP_JALR);
  assign branch     = (opcode == `RV_OP_BRANCH);
  assign mem_read   = (opcode == `RV_OP_LOAD);
  assign mem_to_reg = (opcode == `RV_OP_LOAD);
  assign pc_to_reg  = is_jal || is_jalr;
  assign is_ecall   = (opcode == `RV_OP_ECALL);

  // second operand is rs2 only for register arithmetic and branch compares
  assign alu_src = (opcode != `RV_OP_ARITH) && (opcode != `RV_OP_BRANCH);

  // only these formats have a destination register
  // ecall, stores, branches and unknown words leave the register file alone
  assign writes_rd = (opcode == `RV_OP_ARITH) || (opcode == `RV_OP_ARITH_IMM) ||
                     (opcode == `RV_OP_LOAD) || is_jal || is_jalr;

  // a halted core retires nothing
  assign reg_write = writes_rd && !halted;
  assign mem_write = (opcode == `RV_OP_STORE) && !halted;

  // alu control
  always_comb begin
    case (opcode)
      `RV_OP_ARITH: begin
        // funct7 only matters for add/sub
        if (funct3 == `RV_F3_ADD && funct7 == `RV_F7_SUB) begin
          alu_op = `RV_ALU_SUB;
        end else begin
          alu_op = funct3;
        end
      end
      `RV_OP_ARITH_IMM: alu_op = funct3;
      // address calculation
      `RV_OP_LOAD, `RV_OP_STORE, `RV_OP_JALR: alu_op = `RV_ALU_ADD;
      // compare through the sub path
      `RV_OP_BRANCH: alu_op = `RV_ALU_SUB;
      default: alu_op = `RV_ALU_ADD;
    endcase
  end

endmodule

// File: hw/pc_unit.sv
`timescale 1ns/1ps

module pc_unit (
  input  logic          clk,
  input  logic          reset,
  input  logic          is_jal,
  input  logic          is_jalr,
  input  logic          branch,
  input  logic          bcond,
  input  logic          is_ecall,
  input  rv_pkg::word_t imm,
  input  rv_pkg::word_t alu_result,
  output rv_pkg::word_t pc,
  output logic          halted
);

  rv_pkg::word_t next_pc;

  // jalr target comes from the alu (rs1 + imm), bit 0 dropped
  // jal and taken branches are pc relative
  always_comb begin
    if (is_jalr) begin
      next_pc = {alu_result[31:1], 1'b0};
    end else if (is_jal || (branch && bcond)) begin
      next_pc = pc + imm;
    end else begin
      next_pc = pc + 32'd4;
    end
  end

  // halt is sticky until reset, the pc stays on the ecall
  always_ff @(posedge clk) begin
    if (reset) begin
      pc     <= '0;
      halted <= 1'b0;
    end else begin
      halted <= halted | is_ecall;
      if (!halted && !is_ecall) begin
        pc <= next_pc;
      end
    end
  end

endmodule

// File: hw/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

  // datum, address or instruction word
  typedef logic [`RV_XLEN-1:0] word_t;

  // register index, x0..x31
  typedef logic [4:0] reg_idx_t;

  // operation code handed from the decoder to the alu
  typedef logic [2:0] alu_op_t;

  // instruction fields
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;

endpackage

// File: include/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// major opcodes, instr[6:0]
`define RV_OP_ARITH      7'b0110011
`define RV_OP_ARITH_IMM  7'b0010011
`define RV_OP_LOAD       7'b0000011
`define RV_OP_STORE      7'b0100011
`define RV_OP_BRANCH     7'b1100011
`define RV_OP_JAL        7'b1101111
`define RV_OP_JALR       7'b1100111
`define RV_OP_ECALL      7'b1110011

// funct3 for arithmetic, register and immediate forms share these
`define RV_F3_ADD        3'b000
`define RV_F3_SLL        3'b001
`define RV_F3_XOR        3'b100
`define RV_F3_SRL        3'b101
`define RV_F3_OR         3'b110
`define RV_F3_AND        3'b111

// funct3 for conditional branches
`define RV_F3_BEQ        3'b000
`define RV_F3_BNE        3'b001
`define RV_F3_BLT        3'b100
`define RV_F3_BGE        3'b101

// funct7 that turns add into sub for register arithmetic
`define RV_F7_SUB        7'b0100000

// alu op codes, mostly equal to funct3 so the decoder stays small
// sub sits on the slot that slt would use, slt is not supported
`define RV_ALU_ADD       3'b000
`define RV_ALU_SLL       3'b001
`define RV_ALU_SUB       3'b010
`define RV_ALU_XOR       3'b100
`define RV_ALU_SRL       3'b101
`define RV_ALU_OR        3'b110
`define RV_ALU_AND       3'b111

// sizes
`define RV_IMEM_WORDS    64
`define RV_DMEM_WORDS    64
`define RV_XLEN          32

`endif
